// File: Makefile
TOOL     := verilator
TOP      := tb_ht_top
FILELIST := list.f
FLAGS    := --binary --timing -Wno-fatal --top-module $(TOP)
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run and check the log"
	@echo "make clean  remove build output and log"

test:
	$(TOOL) $(FLAGS) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q -F "** PASS **" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: hw/ht_compare.sv
`default_nettype none
`timescale 1ns/1ns

module ht_compare #(
	parameter int TABLE_ADDR_WIDTH = ht_pkg::TABLE_ADDR_WIDTH
) (
	input wire clk,
	input wire rst_regd,
	input wire ht_pkg::ht_req_t in_req,
	input wire in_valid,
	output logic in_ready,
	input wire ht_pkg::ht_line_t mem_rd_data,
	input wire mem_rd_data_valid,
	output logic mem_rd_data_ready,
	output ht_pkg::ht_lookup_t out_lookup,
	output logic out_valid,
	input wire out_ready
);

	localparam int IW = ht_pkg::SLOT_IDX_WIDTH;

	typedef enum logic [1:0] {
		C_IDLE,
		C_BEAT1,
		C_BEAT2,
		C_OUT
	} state_e;

	state_e state;
	logic same_line;
	logic [IW:0] m1;
	logic [IW:0] m2;
	logic [IW:0] e1;
	logic [IW:0] e2;

	// found flag on top, slot index below; lowest slot wins
	function automatic logic [IW:0] find_key(input ht_pkg::ht_line_t bucket,
			input logic [ht_pkg::KEY_WIDTH-1:0] key);
		logic [IW:0] res;
		res = '0;
		for (int i = ht_pkg::SLOTS - 1; i >= 0; i--) begin
			if (bucket[i].key == key) begin
				res = {1'b1, i[IW-1:0]};
			end
		end
		return res;
	endfunction

	assign in_ready = (state == C_IDLE);
	assign mem_rd_data_ready = (state == C_BEAT1) || (state == C_BEAT2);

	// both hashes may name one bucket, then line 2 adds nothing
	assign same_line = (out_lookup.req.hash1[TABLE_ADDR_WIDTH-1:0] ==
			out_lookup.req.hash2[TABLE_ADDR_WIDTH-1:0]);

	always_comb begin
		m1 = find_key(out_lookup.line1, out_lookup.req.key);
		m2 = find_key(mem_rd_data, out_lookup.req.key);
		e1 = find_key(out_lookup.line1, '0);
		e2 = find_key(mem_rd_data, '0);
	end

	always_ff @(posedge clk) begin
		if (rst_regd) begin
			state <= C_IDLE;
			out_valid <= 1'b0;
		end else begin
			case (state)
				C_IDLE: begin
					if (in_valid) begin
						out_lookup.req <= in_req;
						out_lookup.match <= 1'b0;
						out_lookup.empty <= 1'b0;
						if (in_req.op == ht_pkg::OP_IGNORE) begin
							out_valid <= 1'b1;
							state <= C_OUT;
						end else begin
							state <= C_BEAT1;
						end
					end
				end
				C_BEAT1: begin
					if (mem_rd_data_valid) begin
						out_lookup.line1 <= mem_rd_data;
						state <= C_BEAT2;
					end
				end
				C_BEAT2: begin
					if (mem_rd_data_valid) begin
						out_lookup.line2 <= mem_rd_data;
						out_lookup.match <= m1[IW] || (m2[IW] && !same_line);
						out_lookup.match_sel <= !m1[IW];
						out_lookup.match_idx <= m1[IW] ? m1[IW-1:0] : m2[IW-1:0];
						out_lookup.empty <= e1[IW] || (e2[IW] && !same_line);
						out_lookup.empty_sel <= !e1[IW];
						out_lookup.empty_idx <= e1[IW] ? e1[IW-1:0] : e2[IW-1:0];
						out_valid <= 1'b1;
						state <= C_OUT;
					end
				end
				default: begin
					if (out_ready) begin
						out_valid <= 1'b0;
						state <= C_IDLE;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/ht_fetch.sv
`default_nettype none
`timescale 1ns/1ns

module ht_fetch #(
	parameter int TABLE_ADDR_WIDTH = ht_pkg::TABLE_ADDR_WIDTH
) (
	input wire clk,
	input wire rst_regd,
	input wire ht_pkg::ht_req_t req,
	input wire req_valid,
	output logic req_ready,
	output logic [TABLE_ADDR_WIDTH-1:0] mem_rd_addr,
	output logic mem_rd_valid,
	input wire mem_rd_ready,
	output ht_pkg::ht_req_t out_req,
	output logic out_valid,
	input wire out_ready,
	input wire done
);

	typedef enum logic [1:0] {
		F_IDLE,
		F_RD1,
		F_RD2,
		F_OUT
	} state_e;

	localparam int LOCKS = 4;

	state_e state;
	logic [LOCKS-1:0] lock_valid;
	logic [TABLE_ADDR_WIDTH-1:0] lock_h1 [LOCKS];
	logic [TABLE_ADDR_WIDTH-1:0] lock_h2 [LOCKS];
	logic [1:0] lock_head;
	logic [1:0] lock_tail;
	logic lock_hit;
	logic can_accept;
	logic take;

	// a bucket already in flight blocks the request until its writeback is done
	always_comb begin
		lock_hit = 1'b0;
		for (int i = 0; i < LOCKS; i++) begin
			if (lock_valid[i] && (lock_h1[i] == req.hash1 || lock_h1[i] == req.hash2 ||
					lock_h2[i] == req.hash1 || lock_h2[i] == req.hash2)) begin
				lock_hit = 1'b1;
			end
		end
	end

	assign can_accept = !(&lock_valid) && !lock_hit;
	assign take = req_valid && req_ready;

	always_ff @(posedge clk) begin
		if (rst_regd) begin
			state <= F_IDLE;
			req_ready <= 1'b0;
			mem_rd_valid <= 1'b0;
			out_valid <= 1'b0;
			lock_valid <= '0;
			lock_head <= '0;
			lock_tail <= '0;
		end else begin
			// responses leave in order, so the oldest entry retires
			if (done) begin
				lock_valid[lock_tail] <= 1'b0;
				lock_tail <= lock_tail + 2'd1;
			end

			case (state)
				F_IDLE: begin
					req_ready <= req_valid && !req_ready && can_accept;
					if (take) begin
						req_ready <= 1'b0;
						out_req <= req;
						if (req.op == ht_pkg::OP_IGNORE) begin
							out_valid <= 1'b1;
							state <= F_OUT;
						end else begin
							lock_valid[lock_head] <= 1'b1;
							lock_h1[lock_head] <= req.hash1;
							lock_h2[lock_head] <= req.hash2;
							lock_head <= lock_head + 2'd1;
							mem_rd_addr <= req.hash1;
							mem_rd_valid <= 1'b1;
							state <= F_RD1;
						end
					end
				end
				F_RD1: begin
					if (mem_rd_ready) begin
						mem_rd_addr <= out_req.hash2;
						state <= F_RD2;
					end
				end
				F_RD2: begin
					if (mem_rd_ready) begin
						mem_rd_valid <= 1'b0;
						out_valid <= 1'b1;
						state <= F_OUT;
					end
				end
				default: begin
					if (out_ready) begin
						out_valid <= 1'b0;
						state <= F_IDLE;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/ht_pkg.sv
`default_nettype none

package ht_pkg;

	localparam int KEY_WIDTH = 32;
	localparam int LEN_WIDTH = 16;
	localparam int PTR_WIDTH = 32;
	localparam int SLOTS = 4;
	localparam int TAG_WIDTH = 16;

	// hash fields of the structs follow this; ht_top defaults its parameter to it
	localparam int TABLE_ADDR_WIDTH = 10;

	localparam int SLOT_IDX_WIDTH = $clog2(SLOTS);
	localparam int ENTRY_WIDTH = KEY_WIDTH + LEN_WIDTH + PTR_WIDTH;
	localparam int LINE_WIDTH = SLOTS * ENTRY_WIDTH;

	typedef enum logic [1:0] {
		OP_GET,
		OP_SET,
		OP_DEL,
		OP_IGNORE
	} ht_op_e;

	typedef enum logic [1:0] {
		ST_OK,
		ST_NOT_FOUND,
		ST_FULL,
		ST_NO_MEMORY
	} ht_status_e;

	// key of zero marks an empty slot
	typedef struct packed {
		logic [KEY_WIDTH-1:0] key;
		logic [LEN_WIDTH-1:0] len;
		logic [PTR_WIDTH-1:0] addr;
	} ht_entry_t;

	typedef ht_entry_t [SLOTS-1:0] ht_line_t;

	typedef struct packed {
		ht_op_e op;
		logic [TAG_WIDTH-1:0] tag;
		logic [KEY_WIDTH-1:0] key;
		logic [LEN_WIDTH-1:0] len;
		logic [TABLE_ADDR_WIDTH-1:0] hash1;
		logic [TABLE_ADDR_WIDTH-1:0] hash2;
	} ht_req_t;

	// sel of 0 points at line1, 1 at line2
	typedef struct packed {
		ht_req_t req;
		ht_line_t line1;
		ht_line_t line2;
		logic match;
		logic match_sel;
		logic [SLOT_IDX_WIDTH-1:0] match_idx;
		logic empty;
		logic empty_sel;
		logic [SLOT_IDX_WIDTH-1:0] empty_idx;
	} ht_lookup_t;

	typedef struct packed {
		logic [TAG_WIDTH-1:0] tag;
		ht_op_e op;
		ht_status_e status;
		logic [LEN_WIDTH-1:0] len;
		logic [PTR_WIDTH-1:0] addr;
	} ht_resp_t;

	typedef struct packed {
		ht_line_t line;
		logic [TABLE_ADDR_WIDTH-1:0] addr;
		logic wr_en;
		ht_resp_t resp;
	} ht_wb_t;

endpackage

`default_nettype wire

// File: hw/ht_top.sv
`default_nettype none
`timescale 1ns/1ns

module ht_top #(
	parameter int TABLE_ADDR_WIDTH = ht_pkg::TABLE_ADDR_WIDTH
) (
	input wire clk,
	input wire rst_regd,

	input wire [1:0] req_op,
	input wire [ht_pkg::TAG_WIDTH-1:0] req_tag,
	input wire [ht_pkg::KEY_WIDTH-1:0] req_key,
	input wire [ht_pkg::LEN_WIDTH-1:0] req_len,
	input wire [TABLE_ADDR_WIDTH-1:0] req_hash1,
	input wire [TABLE_ADDR_WIDTH-1:0] req_hash2,
	input wire req_valid,
	output logic req_ready,

	output logic [TABLE_ADDR_WIDTH-1:0] mem_rd_addr,
	output logic mem_rd_valid,
	input wire mem_rd_ready,
	input wire [ht_pkg::LINE_WIDTH-1:0] mem_rd_data,
	input wire mem_rd_data_valid,
	output logic mem_rd_data_ready,

	output logic [TABLE_ADDR_WIDTH-1:0] mem_wr_addr,
	output logic [ht_pkg::LINE_WIDTH-1:0] mem_wr_data,
	output logic mem_wr_valid,
	input wire mem_wr_ready,

	input wire [ht_pkg::PTR_WIDTH-1:0] malloc_addr,
	input wire malloc_failed,
	input wire malloc_valid,
	output logic malloc_ready,

	output logic [ht_pkg::PTR_WIDTH-1:0] free_addr,
	output logic [ht_pkg::LEN_WIDTH-1:0] free_len,
	output logic free_valid,
	input wire free_ready,

	output logic [ht_pkg::TAG_WIDTH-1:0] resp_tag,
	output logic [1:0] resp_op,
	output logic [1:0] resp_status,
	output logic [ht_pkg::LEN_WIDTH-1:0] resp_len,
	output logic [ht_pkg::PTR_WIDTH-1:0] resp_addr,
	output logic resp_valid,
	input wire resp_ready
);

	ht_pkg::ht_req_t req;
	ht_pkg::ht_req_t f2c_req;
	logic f2c_valid;
	logic f2c_ready;
	ht_pkg::ht_lookup_t c2u_lookup;
	logic c2u_valid;
	logic c2u_ready;
	ht_pkg::ht_wb_t u2w_wb;
	logic u2w_valid;
	logic u2w_ready;
	ht_pkg::ht_line_t wr_line;
	ht_pkg::ht_resp_t resp;
	logic wb_done;

	assign req.op = ht_pkg::ht_op_e'(req_op);
	assign req.tag = req_tag;
	assign req.key = req_key;
	assign req.len = req_len;
	assign req.hash1 = req_hash1;
	assign req.hash2 = req_hash2;

	assign mem_wr_data = wr_line;

	assign resp_tag = resp.tag;
	assign resp_op = resp.op;
	assign resp_status = resp.status;
	assign resp_len = resp.len;
	assign resp_addr = resp.addr;

	// ------------------------------
	// fetch -> compare -> update -> writeback
	ht_fetch #(
		.TABLE_ADDR_WIDTH(TABLE_ADDR_WIDTH)
	) u_fetch (
		.clk(clk),
		.rst_regd(rst_regd),
		.req(req),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.mem_rd_addr(mem_rd_addr),
		.mem_rd_valid(mem_rd_valid),
		.mem_rd_ready(mem_rd_ready),
		.out_req(f2c_req),
		.out_valid(f2c_valid),
		.out_ready(f2c_ready),
		.done(wb_done)
	);

	ht_compare #(
		.TABLE_ADDR_WIDTH(TABLE_ADDR_WIDTH)
	) u_compare (
		.clk(clk),
		.rst_regd(rst_regd),
		.in_req(f2c_req),
		.in_valid(f2c_valid),
		.in_ready(f2c_ready),
		.mem_rd_data(ht_pkg::ht_line_t'(mem_rd_data)),
		.mem_rd_data_valid(mem_rd_data_valid),
		.mem_rd_data_ready(mem_rd_data_ready),
		.out_lookup(c2u_lookup),
		.out_valid(c2u_valid),
		.out_ready(c2u_ready)
	);

	ht_update #(
		.TABLE_ADDR_WIDTH(TABLE_ADDR_WIDTH)
	) u_update (
		.clk(clk),
		.rst_regd(rst_regd),
		.in_lookup(c2u_lookup),
		.in_valid(c2u_valid),
		.in_ready(c2u_ready),
		.malloc_addr(malloc_addr),
		.malloc_failed(malloc_failed),
		.malloc_valid(malloc_valid),
		.malloc_ready(malloc_ready),
		.free_addr(free_addr),
		.free_len(free_len),
		.free_valid(free_valid),
		.free_ready(free_ready),
		.out_wb(u2w_wb),
		.out_valid(u2w_valid),
		.out_ready(u2w_ready)
	);

	ht_writeback #(
		.TABLE_ADDR_WIDTH(TABLE_ADDR_WIDTH)
	) u_writeback (
		.clk(clk),
		.rst_regd(rst_regd),
		.in_wb(u2w_wb),
		.in_valid(u2w_valid),
		.in_ready(u2w_ready),
		.mem_wr_addr(mem_wr_addr),
		.mem_wr_data(wr_line),
		.mem_wr_valid(mem_wr_valid),
		.mem_wr_ready(mem_wr_ready),
		.resp(resp),
		.resp_valid(resp_valid),
		.resp_ready(resp_ready),
		.done(wb_done)
	);

endmodule

`default_nettype wire

// File: hw/ht_update.sv
`default_nettype none
`timescale 1ns/1ns

module ht_update #(
	parameter int TABLE_ADDR_WIDTH = ht_pkg::TABLE_ADDR_WIDTH
) (
	input wire clk,
	input wire rst_regd,
	input wire ht_pkg::ht_lookup_t in_lookup,
	input wire in_valid,
	output logic in_ready,
	input wire [ht_pkg::PTR_WIDTH-1:0] malloc_addr,
	input wire malloc_failed,
	input wire malloc_valid,
	output logic malloc_ready,
	output logic [ht_pkg::PTR_WIDTH-1:0] free_addr,
	output logic [ht_pkg::LEN_WIDTH-1:0] free_len,
	output logic free_valid,
	input wire free_ready,
	output ht_pkg::ht_wb_t out_wb,
	output logic out_valid,
	input wire out_ready
);

	typedef enum logic [1:0] {
		U_IDLE,
		U_ALLOC,
		U_FREE,
		U_EMIT
	} state_e;

	state_e state;
	ht_pkg::ht_lookup_t lk;
	ht_pkg::ht_wb_t wb_next;
	ht_pkg::ht_entry_t hit_entry;
	ht_pkg::ht_entry_t new_entry;
	logic need_free;
	logic [ht_pkg::PTR_WIDTH-1:0] free_addr_next;
	logic [ht_pkg::LEN_WIDTH-1:0] free_len_next;
	logic tgt_sel;
	logic [ht_pkg::SLOT_IDX_WIDTH-1:0] tgt_idx;
	logic [TABLE_ADDR_WIDTH-1:0] tgt_addr;
	logic decide;

	assign in_ready = (state == U_IDLE);
	assign malloc_ready = (state == U_ALLOC) && (lk.req.op == ht_pkg::OP_SET);
	assign free_valid = (state == U_FREE);
	assign out_valid = (state == U_EMIT);

	// only SET waits on the allocator
	assign decide = (state == U_ALLOC) && (lk.req.op != ht_pkg::OP_SET || malloc_valid);

	// ------------------------------
	// operation rules
	always_comb begin
		hit_entry = lk.match_sel ? lk.line2[lk.match_idx] : lk.line1[lk.match_idx];
		new_entry = '{key: lk.req.key, len: lk.req.len, addr: malloc_addr};
		tgt_sel = lk.match_sel;
		tgt_idx = lk.match_idx;
		need_free = 1'b0;
		free_addr_next = hit_entry.addr;
		free_len_next = hit_entry.len;
		wb_next.wr_en = 1'b0;
		wb_next.resp.tag = lk.req.tag;
		wb_next.resp.op = lk.req.op;
		wb_next.resp.status = ht_pkg::ST_OK;
		wb_next.resp.len = '0;
		wb_next.resp.addr = '0;

		case (lk.req.op)
			ht_pkg::OP_GET: begin
				if (lk.match) begin
					wb_next.resp.len = hit_entry.len;
					wb_next.resp.addr = hit_entry.addr;
				end else begin
					wb_next.resp.status = ht_pkg::ST_NOT_FOUND;
				end
			end
			ht_pkg::OP_SET: begin
				if (malloc_failed) begin
					wb_next.resp.status = ht_pkg::ST_NO_MEMORY;
				end else if (lk.match || lk.empty) begin
					// a replaced entry hands back its old pointer
					need_free = lk.match;
					if (!lk.match) begin
						tgt_sel = lk.empty_sel;
						tgt_idx = lk.empty_idx;
					end
					wb_next.wr_en = 1'b1;
					wb_next.resp.len = lk.req.len;
					wb_next.resp.addr = malloc_addr;
				end else begin
					// no room in either line, the fresh pointer goes back
					need_free = 1'b1;
					free_addr_next = malloc_addr;
					free_len_next = lk.req.len;
					wb_next.resp.status = ht_pkg::ST_FULL;
				end
			end
			ht_pkg::OP_DEL: begin
				if (lk.match) begin
					need_free = 1'b1;
					new_entry = '0;
					wb_next.wr_en = 1'b1;
				end else begin
					wb_next.resp.status = ht_pkg::ST_NOT_FOUND;
				end
			end
			default: begin
			end
		endcase

		tgt_addr = tgt_sel ? lk.req.hash2 : lk.req.hash1;
		wb_next.addr = tgt_addr;
		wb_next.line = tgt_sel ? lk.line2 : lk.line1;
		wb_next.line[tgt_idx] = new_entry;
	end

	always_ff @(posedge clk) begin
		if (rst_regd) begin
			state <= U_IDLE;
		end else begin
			case (state)
				U_IDLE: begin
					if (in_valid) begin
						lk <= in_lookup;
						state <= U_ALLOC;
					end
				end
				U_ALLOC: begin
					if (decide) begin
						out_wb <= wb_next;
						free_addr <= free_addr_next;
						free_len <= free_len_next;
						state <= need_free ? U_FREE : U_EMIT;
					end
				end
				U_FREE: begin
					if (free_ready) begin
						state <= U_EMIT;
					end
				end
				default: begin
					if (out_ready) begin
						state <= U_IDLE;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/ht_writeback.sv
`default_nettype none
`timescale 1ns/1ns

module ht_writeback #(
	parameter int TABLE_ADDR_WIDTH = ht_pkg::TABLE_ADDR_WIDTH
) (
	input wire clk,
	input wire rst_regd,
	input wire ht_pkg::ht_wb_t in_wb,
	input wire in_valid,
	output logic in_ready,
	output logic [TABLE_ADDR_WIDTH-1:0] mem_wr_addr,
	output ht_pkg::ht_line_t mem_wr_data,
	output logic mem_wr_valid,
	input wire mem_wr_ready,
	output ht_pkg::ht_resp_t resp,
	output logic resp_valid,
	input wire resp_ready,
	output logic done
);

	typedef enum logic [1:0] {
		W_IDLE,
		W_WRITE,
		W_RESP
	} state_e;

	state_e state;
	ht_pkg::ht_wb_t wb;

	assign in_ready = (state == W_IDLE);
	assign mem_wr_valid = (state == W_WRITE);
	assign resp_valid = (state == W_RESP);
	assign mem_wr_addr = wb.addr;
	assign mem_wr_data = wb.line;
	assign resp = wb.resp;

	// IGNORE never took a lock entry in fetch
	assign done = resp_valid && resp_ready && (wb.resp.op != ht_pkg::OP_IGNORE);

	always_ff @(posedge clk) begin
		if (rst_regd) begin
			state <= W_IDLE;
		end else begin
			case (state)
				W_IDLE: begin
					if (in_valid) begin
						wb <= in_wb;
						state <= in_wb.wr_en ? W_WRITE : W_RESP;
					end
				end
				W_WRITE: begin
					if (mem_wr_ready) begin
						state <= W_RESP;
					end
				end
				default: begin
					if (resp_ready) begin
						state <= W_IDLE;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+tests
hw/ht_pkg.sv
hw/ht_fetch.sv
hw/ht_compare.sv
hw/ht_update.sv
hw/ht_writeback.sv
hw/ht_top.sv
tests/tb_ht_top.sv

// File: tests/ht_model.svh
`ifndef HT_MODEL_SVH
`define HT_MODEL_SVH

localparam int MIRROR_LINES = 16;

logic [31:0] lfsr_state = 32'h1bf74b16;
ht_pkg::ht_line_t mirror [MIRROR_LINES];

// fibonacci LFSR, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	logic fb;
	v = '0;
	for (int i = 0; i < n; i++) begin
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		v = {v[30:0], fb};
	end
	return v;
endfunction

// {found, line, slot}; line 0 is the hash1 line, lowest slot first
function automatic logic [3:0] locate(input logic [3:0] h1, input logic [3:0] h2,
		input logic [31:0] key);
	logic [3:0] h;
	for (int s = 0; s < 2; s++) begin
		h = (s == 0) ? h1 : h2;
		for (int i = 0; i < ht_pkg::SLOTS; i++) begin
			if (mirror[h][i].key == key) begin
				return {1'b1, s[0], i[1:0]};
			end
		end
	end
	return 4'b0000;
endfunction

// one request against the mirror table
task automatic model_apply(input ht_pkg::ht_req_t r, input logic [32:0] alloc,
		output logic [1:0] status, output logic [15:0] len, output logic [31:0] addr,
		output logic frees, output logic [47:0] free_rec);
	logic [3:0] h1;
	logic [3:0] h2;
	logic [3:0] hit;
	logic [3:0] gap;
	logic [3:0] line;
	h1 = r.hash1[3:0];
	h2 = r.hash2[3:0];
	hit = locate(h1, h2, r.key);
	gap = locate(h1, h2, '0);
	line = hit[2] ? h2 : h1;
	status = ht_pkg::ST_OK;
	len = '0;
	addr = '0;
	frees = 1'b0;
	free_rec = '0;
	case (r.op)
		ht_pkg::OP_GET: begin
			if (hit[3]) begin
				len = mirror[line][hit[1:0]].len;
				addr = mirror[line][hit[1:0]].addr;
			end else begin
				status = ht_pkg::ST_NOT_FOUND;
			end
		end
		ht_pkg::OP_SET: begin
			if (alloc[32]) begin
				status = ht_pkg::ST_NO_MEMORY;
			end else if (hit[3]) begin
				frees = 1'b1;
				free_rec = {mirror[line][hit[1:0]].addr, mirror[line][hit[1:0]].len};
				mirror[line][hit[1:0]] = '{key: r.key, len: r.len, addr: alloc[31:0]};
				len = r.len;
				addr = alloc[31:0];
			end else if (gap[3]) begin
				line = gap[2] ? h2 : h1;
				mirror[line][gap[1:0]] = '{key: r.key, len: r.len, addr: alloc[31:0]};
				len = r.len;
				addr = alloc[31:0];
			end else begin
				status = ht_pkg::ST_FULL;
				frees = 1'b1;
				free_rec = {alloc[31:0], r.len};
			end
		end
		ht_pkg::OP_DEL: begin
			if (hit[3]) begin
				frees = 1'b1;
				free_rec = {mirror[line][hit[1:0]].addr, mirror[line][hit[1:0]].len};
				mirror[line][hit[1:0]] = '0;
			end else begin
				status = ht_pkg::ST_NOT_FOUND;
			end
		end
		default: begin
		end
	endcase
endtask

`endif

// File: tests/tb_ht_top.sv
`default_nettype none
`timescale 1ns/1ns

module tb_ht_top;

	localparam int AW = ht_pkg::TABLE_ADDR_WIDTH;
	localparam int N_RANDOM = 400;
	localparam int KEY_RANGE = 12;
	localparam int TIMEOUT_FACTOR = 64;
	localparam int TOTAL_OPS = 17 + N_RANDOM;
	localparam int CYCLE_LIMIT = TIMEOUT_FACTOR * TOTAL_OPS;

	logic clk = 1'b0;
	logic rst_regd = 1'b1;
	logic [1:0] req_op = '0;
	logic [ht_pkg::TAG_WIDTH-1:0] req_tag = '0;
	logic [ht_pkg::KEY_WIDTH-1:0] req_key = '0;
	logic [ht_pkg::LEN_WIDTH-1:0] req_len = '0;
	logic [AW-1:0] req_hash1 = '0;
	logic [AW-1:0] req_hash2 = '0;
	logic req_valid = 1'b0;
	logic req_ready;
	logic [AW-1:0] mem_rd_addr;
	logic mem_rd_valid;
	logic mem_rd_ready = 1'b0;
	logic [ht_pkg::LINE_WIDTH-1:0] mem_rd_data = '0;
	logic mem_rd_data_valid = 1'b0;
	logic mem_rd_data_ready;
	logic [AW-1:0] mem_wr_addr;
	logic [ht_pkg::LINE_WIDTH-1:0] mem_wr_data;
	logic mem_wr_valid;
	logic mem_wr_ready = 1'b0;
	logic [ht_pkg::PTR_WIDTH-1:0] malloc_addr = '0;
	logic malloc_failed = 1'b0;
	logic malloc_valid = 1'b0;
	logic malloc_ready;
	logic [ht_pkg::PTR_WIDTH-1:0] free_addr;
	logic [ht_pkg::LEN_WIDTH-1:0] free_len;
	logic free_valid;
	logic free_ready = 1'b0;
	logic [ht_pkg::TAG_WIDTH-1:0] resp_tag;
	logic [1:0] resp_op;
	logic [1:0] resp_status;
	logic [ht_pkg::LEN_WIDTH-1:0] resp_len;
	logic [ht_pkg::PTR_WIDTH-1:0] resp_addr;
	logic resp_valid;
	logic resp_ready = 1'b0;

	`include "ht_model.svh"

	ht_pkg::ht_line_t mem [1 << AW];
	ht_pkg::ht_req_t stim_q[$];
	ht_pkg::ht_req_t sent_q[$];
	ht_pkg::ht_req_t req_cur;
	logic [AW-1:0] rd_q[$];
	logic [32:0] malloc_q[$];
	logic [47:0] free_q[$];
	logic [31:0] next_ptr = 32'h1000;
	logic [15:0] tag_next = '0;
	int alloc_fail_mode = 0;
	int neg_count = 0;
	int cycle_count = 0;
	int errors = 0;
	int checks = 0;
	int err_mark = 0;
	int write_count = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	// transfers seen at the last falling edge, taken at the rising edge after it
	logic req_fire = 1'b0;
	logic rd_fire = 1'b0;
	logic data_fire = 1'b0;
	logic wr_fire = 1'b0;
	logic malloc_fire = 1'b0;
	logic free_fire = 1'b0;
	logic resp_fire = 1'b0;
	logic [AW-1:0] rd_addr_snap;
	logic [AW-1:0] wr_addr_snap;
	logic [ht_pkg::LINE_WIDTH-1:0] wr_data_snap;
	logic [47:0] free_snap;
	ht_pkg::ht_resp_t resp_snap;

	ht_top #(
		.TABLE_ADDR_WIDTH(AW)
	) DUT (
		.clk(clk),
		.rst_regd(rst_regd),
		.req_op(req_op),
		.req_tag(req_tag),
		.req_key(req_key),
		.req_len(req_len),
		.req_hash1(req_hash1),
		.req_hash2(req_hash2),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.mem_rd_addr(mem_rd_addr),
		.mem_rd_valid(mem_rd_valid),
		.mem_rd_ready(mem_rd_ready),
		.mem_rd_data(mem_rd_data),
		.mem_rd_data_valid(mem_rd_data_valid),
		.mem_rd_data_ready(mem_rd_data_ready),
		.mem_wr_addr(mem_wr_addr),
		.mem_wr_data(mem_wr_data),
		.mem_wr_valid(mem_wr_valid),
		.mem_wr_ready(mem_wr_ready),
		.malloc_addr(malloc_addr),
		.malloc_failed(malloc_failed),
		.malloc_valid(malloc_valid),
		.malloc_ready(malloc_ready),
		.free_addr(free_addr),
		.free_len(free_len),
		.free_valid(free_valid),
		.free_ready(free_ready),
		.resp_tag(resp_tag),
		.resp_op(resp_op),
		.resp_status(resp_status),
		.resp_len(resp_len),
		.resp_addr(resp_addr),
		.resp_valid(resp_valid),
		.resp_ready(resp_ready)
	);

	initial begin
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("timeout after %0d cycles with %0d responses outstanding",
				cycle_count, sent_q.size());
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic check_field(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	// ------------------------------
	// response against the model
	task automatic check_response();
		ht_pkg::ht_req_t r;
		logic [32:0] alloc;
		logic [1:0] st;
		logic [15:0] len;
		logic [31:0] addr;
		logic frees;
		logic [47:0] free_rec;
		logic [47:0] got_free;
		alloc = '0;
		assert (sent_q.size() > 0) else begin
			errors++;
			$display("ERROR at %0t: response tag %0h came with no request outstanding",
				$time, resp_snap.tag);
		end
		if (sent_q.size() == 0) begin
			return;
		end
		r = sent_q.pop_front();
		if (r.op == ht_pkg::OP_SET) begin
			assert (malloc_q.size() > 0) else begin
				errors++;
				$display("ERROR at %0t: SET tag %0h answered without an allocation",
					$time, r.tag);
			end
			if (malloc_q.size() > 0) begin
				alloc = malloc_q.pop_front();
			end
		end
		model_apply(r, alloc, st, len, addr, frees, free_rec);
		check_field("resp_tag", resp_snap.tag, r.tag);
		check_field("resp_op", resp_snap.op, r.op);
		check_field("resp_status", resp_snap.status, st);
		check_field("resp_len", resp_snap.len, len);
		check_field("resp_addr", resp_snap.addr, addr);
		if (frees) begin
			assert (free_q.size() > 0) else begin
				errors++;
				$display("ERROR at %0t: tag %0h should have freed a pointer and did not",
					$time, r.tag);
			end
			if (free_q.size() > 0) begin
				got_free = free_q.pop_front();
				check_field("free_addr", got_free[47:16], free_rec[47:16]);
				check_field("free_len", got_free[15:0], free_rec[15:0]);
			end
		end
	endtask

	// ------------------------------
	// memory, allocator and handshakes
	always @(negedge clk) begin
		neg_count = neg_count + 1;
		if (rst_regd) begin
			if (neg_count == 1) begin
				for (int a = 0; a < (1 << AW); a++) begin
					mem[a] = '0;
				end
				for (int m = 0; m < MIRROR_LINES; m++) begin
					mirror[m] = '0;
				end
			end
			if (neg_count == 5) begin
				rst_regd = 1'b0;
			end
		end else begin
			if (req_fire) begin
				sent_q.push_back(req_cur);
				req_valid = 1'b0;
			end
			if (!req_valid && stim_q.size() > 0 && rand_bits(2) != 0) begin
				req_cur = stim_q.pop_front();
				req_op = req_cur.op;
				req_tag = req_cur.tag;
				req_key = req_cur.key;
				req_len = req_cur.len;
				req_hash1 = req_cur.hash1;
				req_hash2 = req_cur.hash2;
				req_valid = 1'b1;
			end

			if (rd_fire) begin
				rd_q.push_back(rd_addr_snap);
			end
			mem_rd_ready = rand_bits(2) != 0;
			if (data_fire) begin
				mem_rd_data_valid = 1'b0;
			end
			if (!mem_rd_data_valid && rd_q.size() > 0 && rand_bits(1) != 0) begin
				mem_rd_data = mem[rd_q.pop_front()];
				mem_rd_data_valid = 1'b1;
			end

			if (wr_fire) begin
				mem[wr_addr_snap] = wr_data_snap;
				write_count = write_count + 1;
			end
			mem_wr_ready = rand_bits(2) != 0;

			if (malloc_fire) begin
				malloc_q.push_back({malloc_failed, malloc_addr});
				if (!malloc_failed) begin
					next_ptr = next_ptr + 32'h40;
				end
				malloc_valid = 1'b0;
			end
			// offer a pointer only once a SET waits for one
			if (!malloc_valid && malloc_ready && rand_bits(1) != 0) begin
				malloc_addr = next_ptr;
				malloc_failed = (alloc_fail_mode == 1) ||
					(alloc_fail_mode == 2 && rand_bits(3) == 0);
				malloc_valid = 1'b1;
			end

			if (free_fire) begin
				free_q.push_back(free_snap);
			end
			free_ready = rand_bits(2) != 0;

			if (resp_fire) begin
				check_response();
			end
			resp_ready = rand_bits(2) != 0;

			req_fire = req_valid && req_ready;
			rd_fire = mem_rd_valid && mem_rd_ready;
			rd_addr_snap = mem_rd_addr;
			data_fire = mem_rd_data_valid && mem_rd_data_ready;
			wr_fire = mem_wr_valid && mem_wr_ready;
			wr_addr_snap = mem_wr_addr;
			wr_data_snap = mem_wr_data;
			malloc_fire = malloc_valid && malloc_ready;
			free_fire = free_valid && free_ready;
			free_snap = {free_addr, free_len};
			resp_fire = resp_valid && resp_ready;
			resp_snap.tag = resp_tag;
			resp_snap.op = ht_pkg::ht_op_e'(resp_op);
			resp_snap.status = ht_pkg::ht_status_e'(resp_status);
			resp_snap.len = resp_len;
			resp_snap.addr = resp_addr;
		end
	end

	task automatic queue_op(input ht_pkg::ht_op_e op, input int key, input int len,
			input int h1, input int h2);
		ht_pkg::ht_req_t r;
		r.op = op;
		r.tag = tag_next;
		r.key = key;
		r.len = ht_pkg::LEN_WIDTH'(len);
		r.hash1 = AW'(h1);
		r.hash2 = AW'(h2);
		tag_next = tag_next + 16'd1;
		stim_q.push_back(r);
	endtask

	task automatic wait_idle();
		while (stim_q.size() > 0 || sent_q.size() > 0 || req_valid) begin
			@(posedge clk);
		end
	endtask

	task automatic end_test(input int num, input string name);
		wait_idle();
		assert (free_q.size() == 0) else begin
			errors++;
			$display("ERROR at %0t: %0d frees came with no operation that needed them",
				$time, free_q.size());
			free_q.delete();
		end
		if (errors == err_mark) begin
			tests_passed++;
			$display("test %0d %s: ok", num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", num, name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	task automatic compare_memory();
		for (int m = 0; m < MIRROR_LINES; m++) begin
			for (int s = 0; s < ht_pkg::SLOTS; s++) begin
				check_field($sformatf("mem[%0d][%0d].key", m, s), mem[m][s].key,
					mirror[m][s].key);
				check_field($sformatf("mem[%0d][%0d].len", m, s), mem[m][s].len,
					mirror[m][s].len);
				check_field($sformatf("mem[%0d][%0d].addr", m, s), mem[m][s].addr,
					mirror[m][s].addr);
			end
		end
	endtask

	initial begin
		int writes_before;
		logic [1:0] op_bits;
		int key_r;
		int len_r;
		int h1_r;
		int h2_r;
		wait (rst_regd == 1'b0);
		@(posedge clk);

		queue_op(ht_pkg::OP_SET, 101, 12, 1, 2);
		queue_op(ht_pkg::OP_GET, 101, 0, 1, 2);
		end_test(1, "set then get");

		queue_op(ht_pkg::OP_SET, 101, 20, 1, 2);
		queue_op(ht_pkg::OP_GET, 101, 0, 1, 2);
		end_test(2, "replace frees old pointer");

		queue_op(ht_pkg::OP_DEL, 101, 0, 1, 2);
		queue_op(ht_pkg::OP_GET, 101, 0, 1, 2);
		queue_op(ht_pkg::OP_DEL, 101, 0, 1, 2);
		end_test(3, "delete");

		// eight keys fill both lines, the ninth finds no room
		for (int k = 0; k < 8; k++) begin
			queue_op(ht_pkg::OP_SET, 200 + k, 8 + k, 5, 6);
		end
		queue_op(ht_pkg::OP_SET, 208, 30, 5, 6);
		wait_idle();
		alloc_fail_mode = 1;
		writes_before = write_count;
		queue_op(ht_pkg::OP_SET, 209, 4, 7, 8);
		wait_idle();
		assert (write_count == writes_before) else begin
			errors++;
			$display("ERROR at %0t: a SET without memory still wrote the table", $time);
		end
		alloc_fail_mode = 0;
		end_test(4, "full bucket and failed allocation");

		alloc_fail_mode = 2;
		@(posedge clk);
		for (int n = 0; n < N_RANDOM; n++) begin
			op_bits = 2'(rand_bits(2));
			key_r = 1 + int'(rand_bits(8) % KEY_RANGE);
			len_r = 1 + int'(rand_bits(8));
			h1_r = int'(rand_bits(4));
			h2_r = int'(rand_bits(4));
			queue_op(ht_pkg::ht_op_e'(op_bits), key_r, len_r, h1_r, h2_r);
		end
		wait_idle();
		alloc_fail_mode = 0;
		compare_memory();
		end_test(5, "random mix");

		$display("tests passed %0d failed %0d, checks %0d, errors %0d",
			tests_passed, tests_failed, checks, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire
